// File: rtl/video_consts.svh
/* Widths, line buffer depth, depth codes, synchroniser length and hold count */

`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// Screen coordinate and timing threshold width
`define VT_COORD_W 11

// DMA word width
`define VT_WORD_W 32

// Line buffer: top bit picks the buffer, the rest index the word in the line
`define VT_LBUF_AW 9
`define VT_LBUF_DEPTH 512

// Palette colour width and entry count
`define VT_RGB_W 12
`define VT_PAL_N 16

// Depth codes
`define VT_BPP_W 2
`define VT_BPP1 2'd0
`define VT_BPP2 2'd1
`define VT_BPP4 2'd2

// Flyback and request synchroniser stages
`define VT_SYNC_LEN 2

// Minimum cycles the generator is held off during a resync
`define VT_HOLD_CYC 3

`endif

// File: rtl/video_pkg.sv
/* Vector types, resync FSM state, timing config, scan limits and stage-0 beat */

`include "video_consts.svh"

package video_pkg;

   typedef logic [`VT_COORD_W-1:0] coord_t;
   typedef logic [`VT_WORD_W-1:0]  word_t;
   typedef logic [`VT_LBUF_AW-1:0] lbuf_addr_t;
   // Blue 11:8, green 7:4, red 3:0
   typedef logic [`VT_RGB_W-1:0]   rgb12_t;
   typedef logic [`VT_BPP_W-1:0]   bpp_t;

   typedef enum logic [1:0] {
      RS_RUN,
      RS_HOLD,
      RS_WAIT_FLYBACK
   } resync_state_t;

   // Raw segment lengths as programmed from outside
   typedef struct packed {
      coord_t h_res;
      coord_t h_fp;
      coord_t h_sync;
      coord_t h_bp;
      coord_t v_res;
      coord_t v_fp;
      coord_t v_sync;
      coord_t v_bp;
      bpp_t bpp;
      logic [`VT_LBUF_AW-2:0] words_per_line_m1;
   } timing_cfg_t;

   // Cumulative thresholds, each already minus one
   typedef struct packed {
      coord_t h_sync_off;
      coord_t h_disp_start;
      coord_t h_disp_end;
      coord_t h_total;
      coord_t v_sync_off;
      coord_t v_disp_start;
      coord_t v_disp_end;
      coord_t v_total;
      bpp_t bpp;
   } scan_limits_t;

   // Everything that is time aligned at pipeline stage 0
   typedef struct packed {
      logic hsync;
      logic vsync;
      logic de;
      coord_t dispx;
      coord_t dispy;
   } scan_beat_t;

endpackage

// File: rtl/frame_resync.sv
/* Flyback and request synchronisers, resync FSM gating the video enable */

`timescale 1ns/1ps
`include "video_consts.svh"

module frame_resync (
   input  logic pclk,
   input  logic reset,
   input  logic i_sync_flyback,
   input  logic i_config_sync_req,
   output logic o_config_sync_ack,
   output logic o_vid_enable,
   output logic o_flyback_fall
);

   localparam int HOLD_W = $clog2(`VT_HOLD_CYC + 1);

   // Request toggle synchroniser
   logic [`VT_SYNC_LEN-1:0] req_sync;
   // Flyback synchroniser plus one more stage holding the previous value
   logic [`VT_SYNC_LEN:0] fb_sync;
   logic req_pending;
   video_pkg::resync_state_t state;
   logic [HOLD_W-1:0] hold_ctr;

   ////////////////////
   // Synchronisers

   always_ff @(posedge pclk) begin
      if (reset) begin
         req_sync <= '0;
         fb_sync <= '0;
      end else begin
         req_sync <= {req_sync[`VT_SYNC_LEN-2:0], i_config_sync_req};
         fb_sync <= {fb_sync[`VT_SYNC_LEN-1:0], i_sync_flyback};
      end
   end

   // Pending while the resynced request and our ack disagree
   assign req_pending = req_sync[`VT_SYNC_LEN-1] != o_config_sync_ack;

   // One-cycle pulse at the end of flyback
   assign o_flyback_fall = !fb_sync[`VT_SYNC_LEN-1] && fb_sync[`VT_SYNC_LEN];

   ////////////////////
   // Resync FSM

   always_ff @(posedge pclk) begin
      if (reset) begin
         state <= video_pkg::RS_RUN;
         o_vid_enable <= 1'b1;
         o_config_sync_ack <= 1'b0;
         hold_ctr <= '0;
      end else begin
         case (state)
            video_pkg::RS_RUN: begin
               // Stop the generator so it reloads its thresholds
               if (req_pending) begin
                  state <= video_pkg::RS_HOLD;
                  o_vid_enable <= 1'b0;
                  hold_ctr <= HOLD_W'(`VT_HOLD_CYC - 1);
               end
            end
            video_pkg::RS_HOLD: begin
               // Minimum hold that may miss a flyback and wait a frame
               if (hold_ctr == '0)
                  state <= video_pkg::RS_WAIT_FLYBACK;
               else
                  hold_ctr <= hold_ctr - HOLD_W'(1);
            end
            video_pkg::RS_WAIT_FLYBACK: begin
               // Flyback done so release the generator and toggle ack
               if (o_flyback_fall) begin
                  state <= video_pkg::RS_RUN;
                  o_vid_enable <= 1'b1;
                  o_config_sync_ack <= ~o_config_sync_ack;
               end
            end
            default: state <= video_pkg::RS_RUN;
         endcase
      end
   end

   // Ack moves only as the generator comes back after the full hold
   a_ack_on_release: assert property (@(posedge pclk) disable iff (reset)
      (o_config_sync_ack != $past(o_config_sync_ack)) |->
         (o_vid_enable && !$past(o_vid_enable) &&
          !$past(o_vid_enable, `VT_HOLD_CYC)));

endmodule

// File: rtl/scan_timing.sv
/* Timing threshold capture, px/py counters, sync, DE and display coordinates */

`timescale 1ns/1ps

module scan_timing (
   input  logic pclk,
   input  logic reset,
   input  logic i_vid_enable,
   input  video_pkg::timing_cfg_t i_cfg,
   output video_pkg::scan_limits_t o_limits,
   output video_pkg::scan_beat_t o_beat
);

   localparam video_pkg::coord_t ONE = video_pkg::coord_t'(1);

   // Running sums of segment lengths, sync first
   video_pkg::coord_t h_sum_bp, h_sum_res, h_sum_fp;
   video_pkg::coord_t v_sum_bp, v_sum_res, v_sum_fp;
   video_pkg::scan_limits_t lim;
   video_pkg::scan_beat_t beat;
   // Physical scan position, sync at coordinate 0
   video_pkg::coord_t px, py;
   logic v_on_display;

   ////////////////////
   // Threshold capture

   assign h_sum_bp = i_cfg.h_sync + i_cfg.h_bp;
   assign h_sum_res = h_sum_bp + i_cfg.h_res;
   assign h_sum_fp = h_sum_res + i_cfg.h_fp;
   assign v_sum_bp = i_cfg.v_sync + i_cfg.v_bp;
   assign v_sum_res = v_sum_bp + i_cfg.v_res;
   assign v_sum_fp = v_sum_res + i_cfg.v_fp;

   // Reloaded every cycle while the generator is held off
   always_ff @(posedge pclk) begin
      if (!i_vid_enable) begin
         lim.h_sync_off <= i_cfg.h_sync - ONE;
         lim.h_disp_start <= h_sum_bp - ONE;
         lim.h_disp_end <= h_sum_res - ONE;
         lim.h_total <= h_sum_fp - ONE;
         lim.v_sync_off <= i_cfg.v_sync - ONE;
         lim.v_disp_start <= v_sum_bp - ONE;
         lim.v_disp_end <= v_sum_res - ONE;
         lim.v_total <= v_sum_fp - ONE;
         lim.bpp <= i_cfg.bpp;
      end
   end

   ////////////////////
   // Scan counters

   always_ff @(posedge pclk) begin
      if (reset) begin
         px <= '0;
         py <= '0;
         v_on_display <= 1'b0;
         beat.hsync <= 1'b1;
         beat.vsync <= 1'b0;
         beat.de <= 1'b0;
         beat.dispx <= '0;
         beat.dispy <= '0;
      end else if (!i_vid_enable) begin
         // Park on the line before the first display line
         px <= '0;
         py <= lim.v_disp_start;
         v_on_display <= 1'b0;
         beat.hsync <= 1'b1;
         beat.vsync <= 1'b0;
         beat.de <= 1'b0;
         beat.dispx <= '0;
         beat.dispy <= '0;
      end else if (px == lim.h_total) begin
         // End of line
         px <= '0;
         beat.hsync <= 1'b1;
         beat.de <= 1'b0;
         beat.dispx <= '0;
         if (py == lim.v_total) begin
            py <= '0;
            beat.vsync <= 1'b1;
         end else begin
            py <= py + ONE;
            if (py == lim.v_disp_start) begin
               v_on_display <= 1'b1;
            end else if (py == lim.v_disp_end) begin
               v_on_display <= 1'b0;
               beat.dispy <= '0;
            end else if (v_on_display) begin
               beat.dispy <= beat.dispy + ONE;
            end
            if (py == lim.v_sync_off)
               beat.vsync <= 1'b0;
         end
      end else begin
         px <= px + ONE;
         // dispx is zero on the first DE pixel
         beat.dispx <= beat.de ? beat.dispx + ONE : '0;
         if (px == lim.h_sync_off)
            beat.hsync <= 1'b0;
         if (px == lim.h_disp_start && v_on_display)
            beat.de <= 1'b1;
         // Later match wins when the display is empty
         if (px == lim.h_disp_end)
            beat.de <= 1'b0;
      end
   end

   assign o_limits = lim;
   assign o_beat = beat;

   // Back porch separates the end of hsync from the first DE pixel
   a_de_after_hsync: assert property (@(posedge pclk) disable iff (reset || !i_vid_enable)
      beat.de |-> (!beat.hsync && !$past(beat.hsync)));

endmodule

// File: rtl/line_buffer.sv
/* Double line buffer RAM with the DMA write pointer */

`timescale 1ns/1ps
`include "video_consts.svh"

module line_buffer (
   input  logic pclk,
   input  logic reset,
   input  logic i_flyback_fall,
   input  logic i_load_dma,
   input  video_pkg::word_t i_data,
   input  logic [`VT_LBUF_AW-2:0] i_words_per_line_m1,
   input  video_pkg::lbuf_addr_t i_rd_addr,
   output video_pkg::word_t o_rd_data
);

   // Buffer 0 holds even lines, buffer 1 odd lines
   video_pkg::word_t mem [`VT_LBUF_DEPTH];
   video_pkg::lbuf_addr_t wr_ptr;
   // Effective write address, frame start forces buffer 0 word 0
   video_pkg::lbuf_addr_t wr_addr;
   logic [`VT_LBUF_AW-2:0] wr_word;
   logic wr_sel;

   assign wr_addr = i_flyback_fall ? '0 : wr_ptr;
   assign wr_sel = wr_addr[`VT_LBUF_AW-1];
   assign wr_word = wr_addr[`VT_LBUF_AW-2:0];

   ////////////////////
   // Write pointer

   always_ff @(posedge pclk) begin
      if (reset) begin
         wr_ptr <= '0;
      end else if (i_load_dma) begin
         // Last word of the line, flip to the other buffer
         if (wr_word == i_words_per_line_m1)
            wr_ptr <= {~wr_sel, {(`VT_LBUF_AW-1){1'b0}}};
         else
            wr_ptr <= wr_addr + video_pkg::lbuf_addr_t'(1);
      end else if (i_flyback_fall) begin
         wr_ptr <= '0;
      end
   end

   ////////////////////
   // RAM

   // Registered read, data one cycle after the address
   always_ff @(posedge pclk) begin
      if (i_load_dma)
         mem[wr_addr] <= i_data;
      o_rd_data <= mem[i_rd_addr];
   end

   // DMA never runs past the configured line length
   a_wr_in_line: assert property (@(posedge pclk) disable iff (reset)
      wr_ptr[`VT_LBUF_AW-2:0] <= i_words_per_line_m1);

endmodule

// File: rtl/pixel_pipe.sv
/* Read address, pixel demux, palette lookup, colour expansion and sync delay */

`timescale 1ns/1ps
`include "video_consts.svh"

module pixel_pipe (
   input  logic pclk,
   input  video_pkg::scan_beat_t i_beat,
   input  video_pkg::bpp_t i_bpp,
   input  video_pkg::rgb12_t [`VT_PAL_N-1:0] i_palette,
   output video_pkg::lbuf_addr_t o_rd_addr,
   input  video_pkg::word_t i_rd_data,
   output logic [7:0] o_r,
   output logic [7:0] o_g,
   output logic [7:0] o_b,
   output logic o_hsync,
   output logic o_vsync,
   output logic o_blank,
   output logic o_de
);

   localparam int IDX_W = $clog2(`VT_PAL_N);
   localparam int XH = `VT_COORD_W - 1;

   // Pixel position inside the word, stage 1
   logic [4:0] xidx1;
   logic [IDX_W-1:0] pix_sel1;
   // Palette index, stage 2
   logic [IDX_W-1:0] pix2;
   // Palette colour, stage 3
   video_pkg::rgb12_t rgb3;
   // Sync delay taps, index is the stage number
   logic [4:1] hs_d;
   logic [4:1] vs_d;
   logic [3:1] de_d;
   logic [4:2] blank_d;

   ////////////////////
   // Stage 0: word address

   // Line parity picks the buffer, dispx scaled by pixels per word
   always_comb begin
      case (i_bpp)
         `VT_BPP1: o_rd_addr = {i_beat.dispy[0], 2'b00, i_beat.dispx[XH:5]};
         `VT_BPP2: o_rd_addr = {i_beat.dispy[0], 1'b0, i_beat.dispx[XH:4]};
         default:  o_rd_addr = {i_beat.dispy[0], i_beat.dispx[XH:3]};
      endcase
   end

   always_ff @(posedge pclk) begin
      xidx1 <= i_beat.dispx[4:0];
   end

   ////////////////////
   // Stage 1: demux

   // Leftmost pixel sits in the least significant bits
   always_comb begin
      case (i_bpp)
         `VT_BPP1: pix_sel1 = IDX_W'(i_rd_data[xidx1]);
         `VT_BPP2: pix_sel1 = IDX_W'(i_rd_data[{xidx1[3:0], 1'b0} +: 2]);
         default:  pix_sel1 = i_rd_data[{xidx1[2:0], 2'b00} +: 4];
      endcase
   end

   ////////////////////
   // Stages 2 to 4

   always_ff @(posedge pclk) begin
      pix2 <= pix_sel1;
      // Palette is quasi-static, read straight from the input
      rgb3 <= i_palette[pix2];
      // 4 to 8 bit expansion, top bit fills the low nibble
      o_r <= {rgb3[3:0], {4{rgb3[3]}}};
      o_g <= {rgb3[7:4], {4{rgb3[7]}}};
      o_b <= {rgb3[11:8], {4{rgb3[11]}}};
   end

   ////////////////////
   // Sync delay line

   always_ff @(posedge pclk) begin
      hs_d <= {hs_d[3:1], i_beat.hsync};
      vs_d <= {vs_d[3:1], i_beat.vsync};
      de_d <= {de_d[2:1], i_beat.de};
      blank_d <= {blank_d[3:2], ~de_d[1]};
   end

   assign o_hsync = hs_d[4];
   assign o_vsync = vs_d[4];
   assign o_blank = blank_d[4];
   // DE leaves one stage early, ahead of blank
   assign o_de = de_d[3];

endmodule

// File: rtl/video_timing.sv
/* Top level: resync FSM, scan timing, line buffer and pixel pipeline */

`timescale 1ns/1ps
`include "video_consts.svh"

module video_timing (
   input  logic pclk,
   input  logic reset,
   // Held stable while a request is pending
   input  video_pkg::timing_cfg_t i_cfg,
   input  video_pkg::rgb12_t [`VT_PAL_N-1:0] i_palette,
   // DMA word strobe on pclk
   input  logic i_load_dma,
   input  video_pkg::word_t i_load_dma_data,
   // Asynchronous flyback level
   input  logic i_sync_flyback,
   // Toggle handshake
   input  logic i_config_sync_req,
   output logic o_config_sync_ack,
   output logic [7:0] o_r,
   output logic [7:0] o_g,
   output logic [7:0] o_b,
   output logic o_hsync,
   output logic o_vsync,
   output logic o_blank,
   output logic o_de
);

   logic vid_enable;
   logic flyback_fall;
   video_pkg::scan_limits_t limits;
   video_pkg::scan_beat_t beat;
   video_pkg::lbuf_addr_t rd_addr;
   video_pkg::word_t rd_data;

   frame_resync u_resync (
      .pclk              (pclk),
      .reset             (reset),
      .i_sync_flyback    (i_sync_flyback),
      .i_config_sync_req (i_config_sync_req),
      .o_config_sync_ack (o_config_sync_ack),
      .o_vid_enable      (vid_enable),
      .o_flyback_fall    (flyback_fall)
   );

   scan_timing u_timing (
      .pclk         (pclk),
      .reset        (reset),
      .i_vid_enable (vid_enable),
      .i_cfg        (i_cfg),
      .o_limits     (limits),
      .o_beat       (beat)
   );

   // Line length comes straight from the config, DMA runs ahead of the scan
   line_buffer u_lbuf (
      .pclk                (pclk),
      .reset               (reset),
      .i_flyback_fall      (flyback_fall),
      .i_load_dma          (i_load_dma),
      .i_data              (i_load_dma_data),
      .i_words_per_line_m1 (i_cfg.words_per_line_m1),
      .i_rd_addr           (rd_addr),
      .o_rd_data           (rd_data)
   );

   pixel_pipe u_pipe (
      .pclk      (pclk),
      .i_beat    (beat),
      .i_bpp     (limits.bpp),
      .i_palette (i_palette),
      .o_rd_addr (rd_addr),
      .i_rd_data (rd_data),
      .o_r       (o_r),
      .o_g       (o_g),
      .o_b       (o_b),
      .o_hsync   (o_hsync),
      .o_vsync   (o_vsync),
      .o_blank   (o_blank),
      .o_de      (o_de)
   );

endmodule

// File: dv/tb_video_timing.sv
/* Testbench for video_timing: clock, reset, LFSR stimulus, DMA and palette
   loading, frame model and checks */

`timescale 1ns/1ps
`include "video_consts.svh"

module tb_video_timing;

   localparam int CLK_PERIOD = 40;
   localparam int NUM_TESTS = 6;
   // Largest line and frame the random config can produce
   localparam int MAX_FRAME = 36 * 36;
   localparam int TIMEOUT_CYC = NUM_TESTS * (3 * MAX_FRAME + 100) + 20;
   localparam logic [31:0] SEED = 32'd70813;

   logic pclk;
   logic reset;
   video_pkg::timing_cfg_t cfg;
   video_pkg::rgb12_t [`VT_PAL_N-1:0] palette;
   logic load_dma;
   video_pkg::word_t load_dma_data;
   logic sync_flyback;
   logic sync_req;
   logic sync_ack;
   logic [7:0] r, g, b;
   logic hsync, vsync, blank, de;

   logic [31:0] lfsr;
   // DMA words of display lines 0 and 1, line 0 first
   logic [31:0] dma_words [6];
   logic ack_exp;
   int cycles;
   int test_errs, total_errs, tests_failed;
   // Current test config as plain numbers
   int h_res, h_fp, h_sync, h_bp, v_res, v_fp, v_sync, v_bp;
   int bpp, bits, nw, line_len, frame_len;

   video_timing uut (
      .pclk              (pclk),
      .reset             (reset),
      .i_cfg             (cfg),
      .i_palette         (palette),
      .i_load_dma        (load_dma),
      .i_load_dma_data   (load_dma_data),
      .i_sync_flyback    (sync_flyback),
      .i_config_sync_req (sync_req),
      .o_config_sync_ack (sync_ack),
      .o_r               (r),
      .o_g               (g),
      .o_b               (b),
      .o_hsync           (hsync),
      .o_vsync           (vsync),
      .o_blank           (blank),
      .o_de              (de)
   );

   initial begin
      pclk = 1'b0;
      forever #(CLK_PERIOD / 2) pclk = ~pclk;
   end

   ////////////////////
   // Helpers

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA3000000) : (lfsr >> 1);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // Channel expansion, top bit repeated into the low nibble
   function automatic logic [7:0] widen(input logic [3:0] c);
      return {c, c[3] ? 4'hf : 4'h0};
   endfunction

   // Pixels packed from the word LSB up, left pixel first
   function automatic logic [3:0] pixel_index(input int line, input int k);
      int pos;
      logic [31:0] w;
      logic [3:0] idx;
      pos = k * bits;
      w = dma_words[line * nw + pos / 32];
      idx = '0;
      for (int i = 0; i < bits; i++)
         idx[i] = w[pos % 32 + i];
      return idx;
   endfunction

   // Sample and drive point, just after the rising edge
   task automatic next_cycle();
      @(posedge pclk);
      #2;
   endtask

   task automatic flag_mismatch(input string msg);
      $display("ERR %0t: %s", $time, msg);
      test_errs++;
      total_errs++;
   endtask

   task automatic flag_missing(input string msg);
      $display("Failure at %0t: %s", $time, msg);
      test_errs++;
      total_errs++;
   endtask

   ////////////////////
   // Handshake

   // Request with flyback held high, then release flyback
   task automatic resync_frame();
      logic seen;
      seen = 1'b0;
      sync_flyback = 1'b1;
      next_cycle();
      sync_req = ~sync_req;
      repeat (10) begin
         next_cycle();
         if (sync_ack != ack_exp)
            flag_mismatch("ack toggled while flyback was still high");
      end
      sync_flyback = 1'b0;
      for (int i = 0; i < 8 && !seen; i++) begin
         next_cycle();
         if (sync_ack != ack_exp)
            seen = 1'b1;
      end
      if (!seen)
         flag_missing("no ack within 8 cycles of the flyback falling");
      ack_exp = ~ack_exp;
      // Pipeline flushed with parked values
      if (hsync != 1'b1 || vsync != 1'b0 || de != 1'b0)
         flag_mismatch($sformatf("parked outputs hs %b vs %b de %b", hsync, vsync, de));
   endtask

   ////////////////////
   // Frame checks

   task automatic check_scan();
      int hs_rise, vs_rise, de_run, de_lines, disp_line, pix_k;
      logic hs_prev, vs_prev, de_prev, blank_prev, vs_seen, vs_done;
      logic [3:0] idx;
      logic [23:0] exp_rgb;
      video_pkg::rgb12_t c;
      hs_rise = -1;
      vs_rise = -1;
      de_run = 0;
      de_lines = 0;
      disp_line = 0;
      pix_k = 0;
      vs_seen = 1'b0;
      vs_done = 1'b0;
      hs_prev = hsync;
      vs_prev = vsync;
      de_prev = de;
      blank_prev = blank;
      for (int cyc = 0; cyc < 2 * frame_len + 16; cyc++) begin
         // Fill lines 0 and 1 right after the frame start
         load_dma = cyc < 2 * nw;
         load_dma_data = (cyc < 2 * nw) ? dma_words[cyc] : '0;
         next_cycle();
         if (sync_ack != ack_exp)
            flag_mismatch("ack toggled more than once");
         // Horizontal sync width and line period
         if (hsync && !hs_prev) begin
            if (hs_rise >= 0 && cyc - hs_rise != line_len)
               flag_mismatch($sformatf("hsync period %0d, want %0d", cyc - hs_rise, line_len));
            hs_rise = cyc;
         end
         if (!hsync && hs_prev && hs_rise >= 0 && cyc - hs_rise != h_sync)
            flag_mismatch($sformatf("hsync width %0d, want %0d", cyc - hs_rise, h_sync));
         // Vertical sync spans whole lines, display lines come before it
         if (vsync && !vs_prev && !vs_seen) begin
            vs_seen = 1'b1;
            vs_rise = cyc;
            if (de_lines != v_res)
               flag_mismatch($sformatf("%0d DE lines, want %0d", de_lines, v_res));
         end
         if (!vsync && vs_prev && vs_seen && !vs_done) begin
            vs_done = 1'b1;
            if (cyc - vs_rise != v_sync * line_len)
               flag_mismatch($sformatf("vsync width %0d, want %0d",
                  cyc - vs_rise, v_sync * line_len));
         end
         // Blank trails DE by one cycle
         if (blank != !de_prev)
            flag_mismatch($sformatf("blank %b after DE %b", blank, de_prev));
         if (de)
            de_run++;
         if (!de && de_prev) begin
            if (de_run != h_res)
               flag_mismatch($sformatf("DE run %0d, want %0d", de_run, h_res));
            if (!vs_seen)
               de_lines++;
            de_run = 0;
         end
         // Pixel colour on display lines 0 and 1
         if (!blank) begin
            if (disp_line < 2 && !vs_seen) begin
               idx = pixel_index(disp_line, pix_k);
               c = palette[idx];
               exp_rgb = {widen(c[3:0]), widen(c[7:4]), widen(c[11:8])};
               if ({r, g, b} != exp_rgb)
                  flag_mismatch($sformatf("line %0d pixel %0d rgb %h, want %h",
                     disp_line, pix_k, {r, g, b}, exp_rgb));
            end
            pix_k++;
         end
         if (blank && !blank_prev) begin
            if (pix_k != h_res)
               flag_mismatch($sformatf("blank low for %0d, want %0d", pix_k, h_res));
            pix_k = 0;
            disp_line++;
         end
         hs_prev = hsync;
         vs_prev = vsync;
         de_prev = de;
         blank_prev = blank;
      end
      load_dma = 1'b0;
      if (hs_rise < 0)
         flag_missing("no hsync pulse seen in the frame window");
      if (!vs_done)
         flag_missing("no complete vsync pulse seen in the frame window");
   endtask

   ////////////////////
   // One test

   task automatic run_test(input int t);
      test_errs = 0;
      h_res = 8 + int'(take_bits(5) % 17);
      h_fp = 1 + int'(take_bits(2));
      h_sync = 1 + int'(take_bits(2));
      h_bp = 1 + int'(take_bits(2));
      v_res = 8 + int'(take_bits(5) % 17);
      v_fp = 1 + int'(take_bits(2));
      v_sync = 1 + int'(take_bits(2));
      v_bp = 1 + int'(take_bits(2));
      // Every depth once, then random ones
      bpp = (t < 3) ? t : int'(take_bits(2) % 3);
      bits = 1 << bpp;
      nw = (h_res * bits + 31) / 32;
      line_len = h_res + h_fp + h_sync + h_bp;
      frame_len = line_len * (v_res + v_fp + v_sync + v_bp);
      cfg.h_res = video_pkg::coord_t'(h_res);
      cfg.h_fp = video_pkg::coord_t'(h_fp);
      cfg.h_sync = video_pkg::coord_t'(h_sync);
      cfg.h_bp = video_pkg::coord_t'(h_bp);
      cfg.v_res = video_pkg::coord_t'(v_res);
      cfg.v_fp = video_pkg::coord_t'(v_fp);
      cfg.v_sync = video_pkg::coord_t'(v_sync);
      cfg.v_bp = video_pkg::coord_t'(v_bp);
      cfg.bpp = video_pkg::bpp_t'(bpp);
      cfg.words_per_line_m1 = 8'(nw - 1);
      for (int i = 0; i < `VT_PAL_N; i++)
         palette[i] = video_pkg::rgb12_t'(take_bits(12));
      for (int i = 0; i < 2 * nw; i++)
         dma_words[i] = take_bits(32);
      resync_frame();
      check_scan();
      if (test_errs != 0)
         tests_failed++;
      $display("Test %0d bpp code %0d h %0d/%0d/%0d/%0d v %0d/%0d/%0d/%0d: %s",
         t, bpp, h_sync, h_bp, h_res, h_fp, v_sync, v_bp, v_res, v_fp,
         (test_errs == 0) ? "ok" : "FAILED");
   endtask

   ////////////////////
   // Main sequence

   initial begin
      reset = 1'b1;
      cfg = '0;
      palette = '0;
      load_dma = 1'b0;
      load_dma_data = '0;
      sync_flyback = 1'b0;
      sync_req = 1'b0;
      lfsr = SEED;
      ack_exp = 1'b0;
      test_errs = 0;
      total_errs = 0;
      tests_failed = 0;
      repeat (4) @(posedge pclk);
      #2;
      reset = 1'b0;
      for (int t = 0; t < NUM_TESTS; t++)
         run_test(t);
      $display("Summary: %0d tests, %0d failed, %0d errors", NUM_TESTS, tests_failed,
         total_errs);
      if (total_errs == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

   // Run limit, three frames per test plus margin
   initial begin
      cycles = 0;
      while (cycles < TIMEOUT_CYC) begin
         @(posedge pclk);
         cycles++;
      end
      $display("Timeout: run went past %0d clock cycles", TIMEOUT_CYC);
      $display("Done: errors found");
      $finish;
   end

endmodule

// File: video_timing.f
+incdir+rtl
rtl/video_pkg.sv
rtl/frame_resync.sv
rtl/scan_timing.sv
rtl/line_buffer.sv
rtl/pixel_pipe.sv
rtl/video_timing.sv
dv/tb_video_timing.sv

// File: run_sim.sh
#!/bin/sh
# Build the video timing testbench with Verilator and run it into a log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
   -f video_timing.f --top-module tb_video_timing -Mdir "$OBJ"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/Vtb_video_timing" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
   echo "Simulation reported failures"
   exit 1
fi

echo "Simulation passed"
exit 0
